// ==== Makefile ====
TOP := read_data_tb
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  --top-module $(TOP) -f sim.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
	  --top-module read_data_top -f sim.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// ==== common/afu_pkg.sv ====
`include "capi_defines.svh"

package afu_pkg;

  typedef enum logic [2:0] {
    CMD_NONE = 3'd0,
    CMD_READ = 3'd1,
    CMD_WED  = 3'd2
  } cmd_type_t;

  // Outstanding command, as kept in the tag table
  typedef struct packed {
    logic                valid;
    cmd_type_t           cmd_type;
    logic [`EA_BITS-1:0] ea;
  } command_record_t;

  // Half line after steering and classification
  typedef struct packed {
    logic                  valid;
    logic                  read_data;
    logic                  wed_data;
    logic [`TAG_BITS-1:0]  tag;
    command_record_t       cmd;
    logic [`HALF_BITS-1:0] data;
  } half_line_t;

  //////////////////////////////////////////////////////////////
  // Work element descriptor layout, low bits first on the line
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [2*`HALF_BITS-225:0] reserved;
    logic [31:0]               flags;
    logic [63:0]               size;
    logic [63:0]               dst_addr;
    logic [63:0]               src_addr;
  } wed_fields_t;

  typedef union packed {
    logic [2*`HALF_BITS-1:0] raw;
    wed_fields_t             wed;
  } wed_line_u;

  typedef struct packed {
    logic [`TAG_BITS-1:0]    tag;
    logic [`EA_BITS-1:0]     ea;
    logic [2*`HALF_BITS-1:0] data;
    logic                    tag_error;
    logic                    data_error;
  } line_out_t;

  typedef struct packed {
    logic [`TAG_BITS-1:0] tag;
    logic [63:0]          src_addr;
    logic [63:0]          dst_addr;
    logic [63:0]          size;
    logic [31:0]          flags;
  } wed_out_t;

endpackage

// ==== common/capi_defines.svh ====
`ifndef CAPI_DEFINES_SVH
`define CAPI_DEFINES_SVH

//////////////////////////////////////////////////////////////
// Host interface widths
//////////////////////////////////////////////////////////////

`define TAG_BITS        8     // Command tag
`define HALF_BITS       512   // One half of a cache line
`define DOUBLE_WORDS    8     // Parity bits per half
`define HALF_ADDR_BITS  6     // Buffer write address
`define EA_BITS         64    // Effective address

//////////////////////////////////////////////////////////////
// Unit-internal sizing
//////////////////////////////////////////////////////////////

`define LINE_FIFO_DEPTH 2     // Assembled lines held for the consumer

`endif

// ==== common/capi_pkg.sv ====
`include "capi_defines.svh"

package capi_pkg;

  // One odd parity bit per 64-bit double word
  typedef logic [`DOUBLE_WORDS-1:0] dw_parity_t;

  // Host write into the read buffer, one half line per write
  typedef struct packed {
    logic                       write_valid;
    logic [`TAG_BITS-1:0]       write_tag;
    logic                       write_tag_parity;   // Odd, over write_tag
    logic [`HALF_ADDR_BITS-1:0] write_address;      // Zero selects the low half
    logic [`HALF_BITS-1:0]      write_data;
    dw_parity_t                 write_parity;
  } buffer_write_t;

endpackage

// ==== read_data/odd_parity.sv ====
`timescale 1ns/1ps

module odd_parity #(
  parameter int WORD_BITS = 64,
  parameter int WORDS     = 8
) (
  input  logic [WORD_BITS*WORDS-1:0] data,
  output logic [WORDS-1:0]           par
);

  // Set when the word alone holds an even count of ones
  genvar i;
  generate
    for (i = 0; i < WORDS; i++) begin : g_word
      assign par[i] = ~^data[i*WORD_BITS +: WORD_BITS];
    end
  endgenerate

endmodule

// ==== read_data/read_data_control.sv ====
`timescale 1ns/1ps
`include "capi_defines.svh"

module read_data_control (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     enabled,
  input  capi_pkg::buffer_write_t  buffer_in,
  input  afu_pkg::command_record_t lookup_cmd,
  output afu_pkg::half_line_t      half_out_0,
  output afu_pkg::half_line_t      half_out_1,
  output logic [1:0]               data_read_error   // {tag, data}
);

  import capi_pkg::*;
  import afu_pkg::*;

  buffer_write_t             latched;
  logic                      latched_valid;
  half_line_t                next_half;
  logic [0:0]                tag_par_calc;
  logic [`DOUBLE_WORDS-1:0]  data_par_calc;
  logic                      tag_err;
  logic                      data_err;

  //////////////////////////////////////////////////////////////
  // Input latch
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      latched_valid <= 1'b0;
    end else begin
      latched_valid <= enabled & buffer_in.write_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer_in.write_valid) begin
      latched <= buffer_in;
    end
  end

  //////////////////////////////////////////////////////////////
  // Parity check
  //////////////////////////////////////////////////////////////

  odd_parity #(
    .WORD_BITS (`TAG_BITS),
    .WORDS     (1)
  ) tag_parity_inst (
    .data (latched.write_tag),
    .par  (tag_par_calc)
  );

  odd_parity #(
    .WORD_BITS (`HALF_BITS / `DOUBLE_WORDS),
    .WORDS     (`DOUBLE_WORDS)
  ) data_parity_inst (
    .data (latched.write_data),
    .par  (data_par_calc)
  );

  assign tag_err  = tag_par_calc[0] ^ latched.write_tag_parity;
  assign data_err = |(data_par_calc ^ latched.write_parity);   // Any double word

  //////////////////////////////////////////////////////////////
  // Classify and steer
  //////////////////////////////////////////////////////////////

  always_comb begin
    next_half       = '0;
    next_half.valid = 1'b1;
    next_half.tag   = latched.write_tag;
    next_half.cmd   = lookup_cmd;
    next_half.data  = latched.write_data;
    case (lookup_cmd.cmd_type)
      CMD_READ: next_half.read_data = 1'b1;
      CMD_WED:  next_half.wed_data  = 1'b1;
      default:  ;                      // Unknown tag, neither flag
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half_out_0      <= '0;
      half_out_1      <= '0;
      data_read_error <= 2'b00;
    end else begin
      half_out_0      <= '0;
      half_out_1      <= '0;
      data_read_error <= 2'b00;
      if (enabled && latched_valid) begin
        if (~|latched.write_address) begin
          half_out_0 <= next_half;    // Low half
        end else begin
          half_out_1 <= next_half;
        end
        data_read_error <= {tag_err, data_err};
      end
    end
  end

endmodule

// ==== sim.f ====
+incdir+common
common/capi_pkg.sv
common/afu_pkg.sv
read_data/odd_parity.sv
read_data/read_data_control.sv
verilog/command_tag_table.sv
verilog/line_assembler.sv
verilog/read_data_top.sv
sim/read_data_tb.sv

// ==== sim/read_data_tb.sv ====
`timescale 1ns/1ps
`include "capi_defines.svh"

module read_data_tb;

  import capi_pkg::*;
  import afu_pkg::*;

  localparam int PERIOD       = 4;
  localparam int LATENCY      = 3;    // Second write to line_valid
  localparam int DRAIN_LIMIT  = 20;
  localparam int PAIR_CYCLES  = 2 + 5 + DRAIN_LIMIT + 2;
  localparam int TOTAL_CYCLES = 12 + 12 * PAIR_CYCLES;   // Reset and twelve pair sequences

  logic                 clock;
  logic                 rstn;
  logic                 enabled;
  buffer_write_t        buffer_in;
  logic                 issue_valid;
  logic [`TAG_BITS-1:0] issue_tag;
  command_record_t      issue_cmd;
  line_out_t            line_out;
  logic                 line_valid;
  logic                 line_ready;
  wed_out_t             wed_out;
  logic                 wed_valid;
  logic                 overflow;

  logic [31:0] lcg_state;
  line_out_t   expected_lines[$];   // Lines the FIFO should hold in order
  wed_out_t    expected_weds[$];
  logic        expected_overflow;
  string       test_name;
  int          error_count;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  read_data_top read_data_top_inst (
    .clock       (clock),
    .rstn        (rstn),
    .enabled     (enabled),
    .buffer_in   (buffer_in),
    .issue_valid (issue_valid),
    .issue_tag   (issue_tag),
    .issue_cmd   (issue_cmd),
    .line_out    (line_out),
    .line_valid  (line_valid),
    .line_ready  (line_ready),
    .wed_out     (wed_out),
    .wed_valid   (wed_valid),
    .overflow    (overflow)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #((TOTAL_CYCLES + 50) * PERIOD);
    $display("watchdog expired while running test %s", test_name);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Random data and parity
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`HALF_BITS-1:0] random_half();
    logic [`HALF_BITS-1:0] value;
    for (int i = 0; i < `HALF_BITS / 32; i++) begin
      value[i*32 +: 32] = next_random();
    end
    return value;
  endfunction

  // Parity bit that makes the count of ones odd
  function automatic logic odd_bit(input logic [63:0] word, input int width);
    int ones;
    ones = 0;
    for (int i = 0; i < width; i++) begin
      ones += int'(word[i]);
    end
    return (ones % 2) == 0;
  endfunction

  function automatic logic [`DOUBLE_WORDS-1:0] dw_parity(input logic [`HALF_BITS-1:0] data);
    logic [`DOUBLE_WORDS-1:0] par;
    for (int i = 0; i < `DOUBLE_WORDS; i++) begin
      par[i] = odd_bit(data[i*64 +: 64], 64);
    end
    return par;
  endfunction

  // WED layout with the low bits first on the line
  function automatic wed_out_t wed_fields(input logic [`TAG_BITS-1:0] tag,
                                          input logic [2*`HALF_BITS-1:0] line);
    wed_out_t w;
    w.tag      = tag;
    w.src_addr = line[63:0];
    w.dst_addr = line[127:64];
    w.size     = line[191:128];
    w.flags    = line[223:192];
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reporting and checks
  ////////////////////////////////////////////////////////////

  task automatic report_error(input string what, input logic [1023:0] expected,
                              input logic [1023:0] actual);
    error_count++;
    $display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
  endtask

  task automatic check_line(input line_out_t exp);
    assert (line_out.tag == exp.tag)
      else report_error("tag", exp.tag, line_out.tag);
    assert (line_out.ea == exp.ea)
      else report_error("ea", exp.ea, line_out.ea);
    assert (line_out.data == exp.data)
      else report_error("data", exp.data, line_out.data);
    assert (line_out.tag_error == exp.tag_error)
      else report_error("tag_error", exp.tag_error, line_out.tag_error);
    assert (line_out.data_error == exp.data_error)
      else report_error("data_error", exp.data_error, line_out.data_error);
  endtask

  // Outputs sampled half a cycle away from the driving edge
  always @(negedge clock) begin : output_monitor
    line_out_t head_line;
    wed_out_t  head_wed;
    if (rstn) begin
      assert (line_valid == (expected_lines.size() != 0))
        else report_error("line_valid", expected_lines.size() != 0, line_valid);
      if (line_valid && line_ready && expected_lines.size() != 0) begin
        head_line = expected_lines.pop_front();   // Transfers on the next edge
        check_line(head_line);
      end
      assert (wed_valid == (expected_weds.size() != 0))
        else report_error("wed_valid", expected_weds.size() != 0, wed_valid);
      if (wed_valid && expected_weds.size() != 0) begin
        head_wed = expected_weds.pop_front();
        assert (wed_out == head_wed)
          else report_error("wed_out", head_wed, wed_out);
      end
      assert (overflow == expected_overflow)
        else report_error("overflow", expected_overflow, overflow);
    end
  end

  held_line_stable: assert property (@(negedge clock) disable iff (!rstn)
      (line_valid && !line_ready) |=> (line_valid && $stable(line_out)))
    else begin
      error_count++;
      $display("%s: line_out changed while waiting for line_ready", test_name);
    end

  overflow_sticky: assert property (@(negedge clock) disable iff (!rstn)
      overflow |=> overflow)
    else begin
      error_count++;
      $display("%s: overflow cleared without a reset", test_name);
    end

  wed_single_pulse: assert property (@(negedge clock) disable iff (!rstn)
      wed_valid |=> !wed_valid)
    else begin
      error_count++;
      $display("%s: wed_valid stayed high for more than one cycle", test_name);
    end

  ////////////////////////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////////////////////////

  task automatic issue_command(input logic [`TAG_BITS-1:0] tag, input cmd_type_t kind,
                               input logic [`EA_BITS-1:0] ea);
    command_record_t rec;
    rec.valid    = 1'b1;
    rec.cmd_type = kind;
    rec.ea       = ea;
    @(posedge clock);
    issue_valid <= 1'b1;
    issue_tag   <= tag;
    issue_cmd   <= rec;
    @(posedge clock);
    issue_valid <= 1'b0;
  endtask

  task automatic write_half(input logic [`TAG_BITS-1:0] tag, input logic high,
                            input logic [`HALF_BITS-1:0] data, input logic bad_tag,
                            input logic [`DOUBLE_WORDS-1:0] bad_dw);
    buffer_write_t            wr;
    logic [`HALF_ADDR_BITS-1:0] addr;
    addr                = `HALF_ADDR_BITS'(next_random() % 63) + 1'b1;   // Never zero
    wr.write_valid      = 1'b1;
    wr.write_tag        = tag;
    wr.write_tag_parity = odd_bit(64'(tag), `TAG_BITS) ^ bad_tag;
    wr.write_address    = high ? addr : '0;
    wr.write_data       = data;
    wr.write_parity     = dw_parity(data) ^ bad_dw;
    @(posedge clock);
    buffer_in <= wr;
  endtask

  // Returns on the edge where the assembler completes the pair
  task automatic send_pair(input logic [`TAG_BITS-1:0] tag, input logic low_first,
                           input logic [`HALF_BITS-1:0] low,
                           input logic [`HALF_BITS-1:0] high,
                           input logic bad_tag, input logic [`DOUBLE_WORDS-1:0] bad_dw);
    write_half(tag, !low_first, low_first ? low : high, bad_tag, '0);
    write_half(tag, low_first, low_first ? high : low, 1'b0, bad_dw);
    @(posedge clock);
    buffer_in.write_valid <= 1'b0;
    repeat (LATENCY - 1) @(posedge clock);
  endtask

  task automatic line_completed(input line_out_t line);
    if (expected_lines.size() >= `LINE_FIFO_DEPTH) begin
      expected_overflow = 1'b1;     // Full FIFO drops the line
    end else begin
      expected_lines.push_back(line);
    end
  endtask

  task automatic read_line(input logic [`TAG_BITS-1:0] tag, input logic low_first,
                           input logic bad_tag, input logic [`DOUBLE_WORDS-1:0] bad_dw);
    logic [`EA_BITS-1:0]   ea;
    logic [`HALF_BITS-1:0] low;
    logic [`HALF_BITS-1:0] high;
    line_out_t             line;
    ea   = {next_random(), next_random()};
    low  = random_half();
    high = random_half();
    issue_command(tag, CMD_READ, ea);
    send_pair(tag, low_first, low, high, bad_tag, bad_dw);
    line            = '0;
    line.tag        = tag;
    line.ea         = ea;
    line.data       = {high, low};
    line.tag_error  = bad_tag;
    line.data_error = |bad_dw;
    line_completed(line);
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    while ((expected_lines.size() != 0 || expected_weds.size() != 0) && waited < limit) begin
      @(posedge clock);
      waited++;
    end
    assert (expected_lines.size() == 0 && expected_weds.size() == 0) else begin
      error_count++;
      $display("%s: expected output not delivered within %0d cycles", test_name, limit);
      expected_lines.delete();
      expected_weds.delete();
    end
    repeat (2) @(posedge clock);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count == test_errors) begin
      $display("test %-24s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %-24s failed with %0d errors", test_name, error_count - test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [`HALF_BITS-1:0]    low;
    logic [`HALF_BITS-1:0]    high;
    logic [`DOUBLE_WORDS-1:0] bad_dw;
    lcg_state         = 32'hd215eff5;
    rstn              = 1'b0;
    enabled           = 1'b0;
    buffer_in         = '0;
    issue_valid       = 1'b0;
    issue_tag         = '0;
    issue_cmd         = '0;
    line_ready        = 1'b0;
    expected_overflow = 1'b0;
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_name         = "reset";
    repeat (10) @(posedge clock);
    rstn       <= 1'b1;
    enabled    <= 1'b1;
    line_ready <= 1'b1;
    @(posedge clock);

    start_test("read line assembly");
    read_line(8'h11, 1'b1, 1'b0, '0);       // Low half first
    wait_drained(DRAIN_LIMIT);
    read_line(8'h12, 1'b0, 1'b0, '0);
    wait_drained(DRAIN_LIMIT);
    finish_test();

    start_test("wed decode");
    low  = random_half();
    high = random_half();
    issue_command(8'h30, CMD_WED, {next_random(), next_random()});
    send_pair(8'h30, 1'b1, low, high, 1'b0, '0);
    expected_weds.push_back(wed_fields(8'h30, {high, low}));
    wait_drained(DRAIN_LIMIT);
    finish_test();

    start_test("tag parity error");
    read_line(8'h41, 1'b1, 1'b1, '0);
    wait_drained(DRAIN_LIMIT);
    finish_test();

    start_test("data parity error");
    bad_dw = `DOUBLE_WORDS'(1) << (next_random() % `DOUBLE_WORDS);
    read_line(8'h52, 1'b0, 1'b0, bad_dw);
    wait_drained(DRAIN_LIMIT);
    finish_test();

    // A full FIFO makes a leaked read line show up as overflow
    start_test("disabled");
    @(posedge clock);
    line_ready <= 1'b0;
    read_line(8'h72, 1'b1, 1'b0, '0);
    read_line(8'h73, 1'b0, 1'b0, '0);       // FIFO now full
    @(posedge clock);
    enabled <= 1'b0;
    issue_command(8'h70, CMD_READ, 64'h1000);
    send_pair(8'h70, 1'b1, random_half(), random_half(), 1'b0, '0);
    issue_command(8'h71, CMD_WED, 64'h2000);
    send_pair(8'h71, 1'b0, random_half(), random_half(), 1'b0, '0);
    repeat (6) @(posedge clock);
    enabled    <= 1'b1;
    line_ready <= 1'b1;
    wait_drained(DRAIN_LIMIT);
    finish_test();

    start_test("back-pressure and overflow");
    @(posedge clock);
    line_ready <= 1'b0;
    read_line(8'h61, 1'b1, 1'b0, '0);
    read_line(8'h62, 1'b0, 1'b0, '0);
    read_line(8'h63, 1'b1, 1'b0, '0);       // Finds the FIFO full
    repeat (3) @(posedge clock);
    line_ready <= 1'b1;
    wait_drained(DRAIN_LIMIT);
    repeat (4) @(posedge clock);
    finish_test();

    $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/command_tag_table.sv ====
`timescale 1ns/1ps
`include "capi_defines.svh"

module command_tag_table (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     issue_valid,
  input  logic [`TAG_BITS-1:0]     issue_tag,
  input  afu_pkg::command_record_t issue_cmd,
  input  logic [`TAG_BITS-1:0]     lookup_tag,
  output afu_pkg::command_record_t lookup_cmd
);

  import afu_pkg::*;

  localparam int ENTRIES = 2 ** `TAG_BITS;

  command_record_t           table_mem [ENTRIES];
  logic [ENTRIES-1:0]        entry_valid;   // One bit per tag

  // Record storage
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      table_mem[issue_tag] <= issue_cmd;
    end
  end

  // Occupancy, an issue with a clear valid retires the tag
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      entry_valid <= '0;
    end else if (issue_valid) begin
      entry_valid[issue_tag] <= issue_cmd.valid;
    end
  end

  // Registered read, lines up with the latched buffer write
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lookup_cmd <= '0;
    end else if (entry_valid[lookup_tag]) begin
      lookup_cmd <= table_mem[lookup_tag];
    end else begin
      lookup_cmd <= '0;                       // Reads as CMD_NONE
    end
  end

endmodule

// ==== verilog/line_assembler.sv ====
`timescale 1ns/1ps
`include "capi_defines.svh"

module line_assembler (
  input  logic                clock,
  input  logic                rstn,
  input  afu_pkg::half_line_t half_out_0,
  input  afu_pkg::half_line_t half_out_1,
  input  logic [1:0]          data_read_error,
  output afu_pkg::line_out_t  line_out,
  output logic                line_valid,
  input  logic                line_ready,
  output afu_pkg::wed_out_t   wed_out,
  output logic                wed_valid,
  output logic                overflow
);

  import afu_pkg::*;

  localparam int DEPTH    = `LINE_FIFO_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  half_line_t              in_half;
  logic                    in_valid;
  logic                    in_slot;        // 1 for the high half
  half_line_t              pend_half;
  logic                    pend_valid;
  logic                    pend_slot;
  logic [1:0]              pend_err;
  logic                    pair_done;
  logic [2*`HALF_BITS-1:0] joined;
  logic [1:0]              joined_err;
  line_out_t               new_line;
  wed_line_u               wed_line;
  line_out_t               fifo_mem [DEPTH];
  logic [PTR_BITS-1:0]     wr_ptr;
  logic [PTR_BITS-1:0]     rd_ptr;
  logic [CNT_BITS-1:0]     count;
  logic                    fifo_full;
  logic                    push;
  logic                    pop;

  //////////////////////////////////////////////////////////////
  // Half pairing
  //////////////////////////////////////////////////////////////

  assign in_valid  = half_out_0.valid | half_out_1.valid;
  assign in_slot   = half_out_1.valid;
  assign in_half   = half_out_1.valid ? half_out_1 : half_out_0;
  assign pair_done = in_valid && pend_valid && (pend_half.tag == in_half.tag)
                     && (pend_slot != in_slot);

  assign joined     = in_slot ? {in_half.data, pend_half.data}
                              : {pend_half.data, in_half.data};
  assign joined_err = pend_err | data_read_error;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pend_valid <= 1'b0;
    end else if (pair_done) begin
      pend_valid <= 1'b0;
    end else if (in_valid) begin
      pend_valid <= 1'b1;         // A stray half is replaced
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && !pair_done) begin
      pend_half <= in_half;
      pend_slot <= in_slot;
      pend_err  <= data_read_error;
    end
  end

  always_comb begin
    new_line            = '0;
    new_line.tag        = in_half.tag;
    new_line.ea         = in_half.cmd.ea;
    new_line.data       = joined;
    new_line.tag_error  = joined_err[1];
    new_line.data_error = joined_err[0];
  end

  //////////////////////////////////////////////////////////////
  // Line FIFO
  //////////////////////////////////////////////////////////////

  assign fifo_full  = (count == CNT_BITS'(DEPTH));
  assign push       = pair_done && in_half.read_data && !fifo_full;
  assign line_valid = (count != '0);
  assign pop        = line_valid && line_ready;
  assign line_out   = line_valid ? fifo_mem[rd_ptr] : '0;

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[wr_ptr] <= new_line;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (pair_done && in_half.read_data && fifo_full) begin
        overflow <= 1'b1;         // Sticky until reset
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // WED decode
  //////////////////////////////////////////////////////////////

  assign wed_line.raw = joined;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_valid <= 1'b0;
      wed_out   <= '0;
    end else begin
      wed_valid <= pair_done && in_half.wed_data;
      wed_out   <= '0;
      if (pair_done && in_half.wed_data) begin
        wed_out.tag      <= in_half.tag;
        wed_out.src_addr <= wed_line.wed.src_addr;
        wed_out.dst_addr <= wed_line.wed.dst_addr;
        wed_out.size     <= wed_line.wed.size;
        wed_out.flags    <= wed_line.wed.flags;
      end
    end
  end

endmodule

// ==== verilog/read_data_top.sv ====
`timescale 1ns/1ps
`include "capi_defines.svh"

module read_data_top (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     enabled,
  input  capi_pkg::buffer_write_t  buffer_in,
  input  logic                     issue_valid,
  input  logic [`TAG_BITS-1:0]     issue_tag,
  input  afu_pkg::command_record_t issue_cmd,
  output afu_pkg::line_out_t       line_out,
  output logic                     line_valid,
  input  logic                     line_ready,
  output afu_pkg::wed_out_t        wed_out,
  output logic                     wed_valid,
  output logic                     overflow
);

  import afu_pkg::*;

  command_record_t lookup_cmd;
  half_line_t      half_out_0;
  half_line_t      half_out_1;
  logic [1:0]      data_read_error;

  command_tag_table command_tag_table_inst (
    .clock       (clock),
    .rstn        (rstn),
    .issue_valid (issue_valid),
    .issue_tag   (issue_tag),
    .issue_cmd   (issue_cmd),
    .lookup_tag  (buffer_in.write_tag),
    .lookup_cmd  (lookup_cmd)
  );

  read_data_control read_data_control_inst (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .buffer_in       (buffer_in),
    .lookup_cmd      (lookup_cmd),
    .half_out_0      (half_out_0),
    .half_out_1      (half_out_1),
    .data_read_error (data_read_error)
  );

  line_assembler line_assembler_inst (
    .clock           (clock),
    .rstn            (rstn),
    .half_out_0      (half_out_0),
    .half_out_1      (half_out_1),
    .data_read_error (data_read_error),
    .line_out        (line_out),
    .line_valid      (line_valid),
    .line_ready      (line_ready),
    .wed_out         (wed_out),
    .wed_valid       (wed_valid),
    .overflow        (overflow)
  );

endmodule
